/* rtl/loader_defs.svh */
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// uart bit time in clk_100mhz cycles
// 16 keeps simulation short, a real 115200 baud link needs 868
`define CLOCKS_PER_BAUD 16

// program word address width (1024 words)
`define PROG_ADDR_BITS 10

`endif

/* rtl/loader_pkg.sv */
package loader_pkg;

    // host command opcodes, ascii W/H/R/S
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h57,
        CMD_HALT  = 8'h48,
        CMD_RESET = 8'h52,
        CMD_START = 8'h53
    } cmd_t;

    // command parser position within a command
    typedef enum logic [1:0] {
        IDLE,   // waiting for opcode
        ADDR,   // collecting word address
        DATA    // collecting instruction word
    } parse_state_t;

    // core run state
    typedef enum logic {
        HALT,
        RUN
    } run_state_t;

endpackage

/* rtl/loader_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

interface loader_if;

    logic [`PROG_ADDR_BITS-1:0] mem_addr;   // program word address
    logic [31:0]                mem_data;   // instruction word
    logic                       mem_valid;  // one-cycle write strobe

    logic halt;     // core control pulses
    logic reset;
    logic start;

    // parser side
    modport src (
        output mem_addr, mem_data, mem_valid,
        output halt, reset, start
    );

    // program memory write port
    modport mem_sink (
        input mem_addr, mem_data, mem_valid
    );

    // run control
    modport ctl_sink (
        input halt, reset, start
    );

endinterface

`default_nettype wire

/* rtl/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module uart_rx (
    input  wire         clk_100mhz,
    input  wire         arst_n,
    input  wire         rxd,
    output logic [7:0]  rx_data,
    output logic        rx_valid
);

    localparam int FULL  = `CLOCKS_PER_BAUD;
    localparam int HALF  = `CLOCKS_PER_BAUD / 2;
    localparam int CNT_W = $clog2(FULL);

    logic [2:0]       rx_sync;      // [1:0] synchronizer, [2] edge history
    logic             rx_s;
    logic             start_edge;
    logic             busy;
    logic [3:0]       bit_idx;      // 0 start, 1..8 data, 9 stop
    logic [CNT_W-1:0] baud_cnt;
    logic [7:0]       shift_q;

    assign rx_s       = rx_sync[1];
    assign start_edge = rx_sync[2] & ~rx_sync[1];   // falling edge only
    assign rx_data    = shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // bit timing

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            rx_sync  <= 3'b111;     // idle line is high
            busy     <= 1'b0;
            bit_idx  <= 4'd0;
            baud_cnt <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[1:0], rxd};
            rx_valid <= 1'b0;

            if (!busy) begin
                if (start_edge) begin
                    busy     <= 1'b1;
                    bit_idx  <= 4'd0;
                    baud_cnt <= CNT_W'(HALF - 1);   // aim for mid start bit
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= CNT_W'(FULL - 1);
                bit_idx  <= bit_idx + 4'd1;
                if (bit_idx == 4'd0) begin
                    if (rx_s) busy <= 1'b0;         // glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= rx_s;               // low stop bit drops the byte
                end
            end
        end
    end

    // data bits, lsb first
    always_ff @(posedge clk_100mhz) begin
        if (busy && baud_cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    a_valid_single: assert property (
        @(posedge clk_100mhz) disable iff (!arst_n)
        rx_valid |=> !rx_valid
    );

endmodule

`default_nettype wire

/* rtl/loader_cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module loader_cmd_parser (
    input  wire         clk_100mhz,
    input  wire         arst_n,
    input  wire  [7:0]  rx_data,
    input  wire         rx_valid,
    loader_if.src       ctl
);

    loader_pkg::parse_state_t state;

    logic [1:0]                 byte_cnt;   // bytes taken in ADDR / DATA
    logic [`PROG_ADDR_BITS-1:0] addr_sr;
    logic [31:0]                data_sr;
    loader_pkg::cmd_t           opcode;

    assign opcode = loader_pkg::cmd_t'(rx_data);

    // payload visible while mem_valid is high
    assign ctl.mem_addr = addr_sr;
    assign ctl.mem_data = data_sr;

    ////////////////////////////////////////////////////////////////////////////
    // command FSM

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            state         <= loader_pkg::IDLE;
            byte_cnt      <= 2'd0;
            ctl.mem_valid <= 1'b0;
            ctl.halt      <= 1'b0;
            ctl.reset     <= 1'b0;
            ctl.start     <= 1'b0;
        end else begin
            // all strobes are single cycle
            ctl.mem_valid <= 1'b0;
            ctl.halt      <= 1'b0;
            ctl.reset     <= 1'b0;
            ctl.start     <= 1'b0;

            if (rx_valid) begin
                case (state)
                    loader_pkg::IDLE: begin
                        case (opcode)
                            loader_pkg::CMD_WRITE: begin
                                state    <= loader_pkg::ADDR;
                                byte_cnt <= 2'd0;
                            end
                            loader_pkg::CMD_HALT:  ctl.halt  <= 1'b1;
                            loader_pkg::CMD_RESET: ctl.reset <= 1'b1;
                            loader_pkg::CMD_START: ctl.start <= 1'b1;
                            default: ;              // unknown opcode, ignored
                        endcase
                    end

                    loader_pkg::ADDR: begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'd1) begin
                            state    <= loader_pkg::DATA;
                            byte_cnt <= 2'd0;
                        end
                    end

                    loader_pkg::DATA: begin
                        byte_cnt <= byte_cnt + 2'd1;    // wraps to 0 after 4th
                        if (byte_cnt == 2'd3) begin
                            state         <= loader_pkg::IDLE;
                            ctl.mem_valid <= 1'b1;
                        end
                    end

                    default: state <= loader_pkg::IDLE;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // address and data shift registers, msb first

    always_ff @(posedge clk_100mhz) begin
        if (rx_valid) begin
            if (state == loader_pkg::ADDR) begin
                // upper address bits beyond the ram size fall off
                addr_sr <= {addr_sr[`PROG_ADDR_BITS-9:0], rx_data};
            end
            if (state == loader_pkg::DATA) begin
                data_sr <= {data_sr[23:0], rx_data};
            end
        end
    end

    a_strobes_onehot: assert property (
        @(posedge clk_100mhz) disable iff (!arst_n)
        $onehot0({ctl.mem_valid, ctl.halt, ctl.reset, ctl.start})
    );

endmodule

`default_nettype wire

/* rtl/program_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module program_ram (
    input  wire                         clk_100mhz,
    loader_if.mem_sink                  wr,
    input  wire  [`PROG_ADDR_BITS-1:0]  fetch_addr,
    output logic [31:0]                 instr
);

    localparam int DEPTH = 1 << `PROG_ADDR_BITS;

    // inferred block ram, contents undefined until loaded
    logic [31:0] mem [0:DEPTH-1];

    ////////////////////////////////////////////////////////////////////////////
    // loader write port

    always_ff @(posedge clk_100mhz) begin
        if (wr.mem_valid) begin
            mem[wr.mem_addr] <= wr.mem_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // fetch port
    // registered read, same-cycle write returns the old word

    always_ff @(posedge clk_100mhz) begin
        instr <= mem[fetch_addr];
    end

endmodule

`default_nettype wire

/* rtl/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control (
    input  wire         clk_100mhz,
    input  wire         arst_n,
    loader_if.ctl_sink  ctl,
    input  wire         step_req,       // clean one-cycle pulse
    output logic        cpu_step,
    output logic        cpu_rst,
    output logic        cpu_running
);

    loader_pkg::run_state_t run_state;
    loader_pkg::run_state_t run_next;

    // start wins over halt
    always_comb begin
        run_next = run_state;
        if (ctl.start) begin
            run_next = loader_pkg::RUN;
        end else if (ctl.halt) begin
            run_next = loader_pkg::HALT;
        end
    end

    always_ff @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            run_state <= loader_pkg::HALT;
            cpu_step  <= 1'b0;
            cpu_rst   <= 1'b0;
        end else begin
            run_state <= run_next;
            cpu_rst   <= ctl.reset;
            // free running, or single steps while halted
            cpu_step  <= (run_next == loader_pkg::RUN) ? 1'b1 : step_req;
        end
    end

    assign cpu_running = (run_state == loader_pkg::RUN);

    a_rst_one_cycle: assert property (
        @(posedge clk_100mhz) disable iff (!arst_n)
        cpu_rst |=> !cpu_rst
    );

endmodule

`default_nettype wire

/* rtl/program_loader_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module program_loader_top (
    input  wire                         clk_100mhz,
    input  wire                         arst_n,
    input  wire                         uart_rxd,
    input  wire                         step_req,
    input  wire  [`PROG_ADDR_BITS-1:0]  fetch_addr,
    output logic [31:0]                 instr,
    output logic                        cpu_step,
    output logic                        cpu_rst,
    output logic                        cpu_running
);

    logic [7:0] rx_data;
    logic       rx_valid;

    loader_if ldr_if ();    // parser outputs

    ////////////////////////////////////////////////////////////////////////////
    // serial command path

    uart_rx urx_i (
        .clk_100mhz (clk_100mhz),
        .arst_n     (arst_n),
        .rxd        (uart_rxd),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

    loader_cmd_parser parser_i (
        .clk_100mhz (clk_100mhz),
        .arst_n     (arst_n),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .ctl        (ldr_if.src)
    );

    ////////////////////////////////////////////////////////////////////////////
    // memory and core control

    program_ram ram_i (
        .clk_100mhz (clk_100mhz),
        .wr         (ldr_if.mem_sink),
        .fetch_addr (fetch_addr),
        .instr      (instr)
    );

    run_control run_i (
        .clk_100mhz  (clk_100mhz),
        .arst_n      (arst_n),
        .ctl         (ldr_if.ctl_sink),
        .step_req    (step_req),
        .cpu_step    (cpu_step),
        .cpu_rst     (cpu_rst),
        .cpu_running (cpu_running)
    );

endmodule

`default_nettype wire

/* verif/loader_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module loader_checker (
    input  wire                         clk_100mhz,
    input  wire                         arst_n,
    input  wire                         step_req,
    input  wire  [`PROG_ADDR_BITS-1:0]  fetch_addr,
    input  wire  [31:0]                 instr,
    input  wire                         cpu_step,
    input  wire                         cpu_rst,
    input  wire                         cpu_running,
    // expectations from the test sequence
    input  wire                         fetch_check,    // fetch_addr valid this cycle
    input  wire                         run_check,      // compare run state now
    input  wire                         exp_running,
    input  int                          exp_rst_count,
    output int                          error_count,
    output int                          check_count
);

    localparam logic [31:0] SEED = 32'h6873;
    localparam logic [31:0] TAPS = 32'h8020_0003;  // taps 32, 22, 2, 1

    int errors = 0;
    int checks = 0;
    int rst_count;

    logic                       step_d1;
    logic                       rst_d1;
    logic                       fetch_d1;
    logic [`PROG_ADDR_BITS-1:0] addr_d1;

    assign error_count = errors;
    assign check_count = checks;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ TAPS) : (s >> 1);
    endfunction

    // expected instruction word for a program address, one lfsr step per bit
    function automatic logic [31:0] ref_word(input logic [`PROG_ADDR_BITS-1:0] addr);
        logic [31:0] state;
        logic [31:0] word;
        state = SEED ^ 32'(addr);
        word  = '0;
        for (int i = 0; i < 32; i++) begin
            state = lfsr_step(state);
            word  = {word[30:0], state[0]};
        end
        return word;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors = errors + 1;
        $display("FAILED %0t: %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare process

    always @(posedge clk_100mhz or negedge arst_n) begin
        if (!arst_n) begin
            step_d1   <= 1'b0;
            rst_d1    <= 1'b0;
            fetch_d1  <= 1'b0;
            addr_d1   <= '0;
            rst_count <= 0;
        end else begin
            step_d1  <= step_req;
            rst_d1   <= cpu_rst;
            fetch_d1 <= fetch_check;
            addr_d1  <= fetch_addr;
            if (cpu_rst) rst_count <= rst_count + 1;

            // free running, or exactly one cycle after a step request
            checks = checks + 1;
            if (cpu_step !== (cpu_running | step_d1)) begin
                report_mismatch("cpu_step", 32'(cpu_running | step_d1), 32'(cpu_step));
            end

            if (cpu_rst && rst_d1) begin
                errors = errors + 1;
                $display("cpu_rst stayed high for more than one cycle at %0t", $time);
            end

            if (fetch_d1) begin     // word fetched one cycle ago
                checks = checks + 1;
                if (instr !== ref_word(addr_d1)) begin
                    report_mismatch("instr", ref_word(addr_d1), instr);
                end
            end

            if (run_check) begin
                checks = checks + 3;
                if (cpu_running !== exp_running) begin
                    report_mismatch("cpu_running", 32'(exp_running), 32'(cpu_running));
                end
                if (cpu_step !== exp_running) begin     // step_req idle here
                    report_mismatch("cpu_step", 32'(exp_running), 32'(cpu_step));
                end
                if (rst_count != exp_rst_count) begin
                    report_mismatch("cpu_rst pulses", 32'(exp_rst_count), 32'(rst_count));
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "loader_defs.svh"

module tb_program_loader;

    localparam int NUM_WORDS    = 16;
    localparam int FRAME_CYCLES = 11 * `CLOCKS_PER_BAUD;   // 8N1 plus one idle bit
    localparam int TEST_BYTES   = NUM_WORDS * 7 + 3 + 2 + 7;
    localparam int TIMEOUT_CYCLES = 2 * TEST_BYTES * FRAME_CYCLES;

    localparam logic [`PROG_ADDR_BITS-1:0] EXTRA_ADDR = 'h1a5;  // odd, never loaded before

    logic                       clk_100mhz = 1'b0;
    logic                       arst_n;
    logic                       uart_rxd;
    logic                       step_req;
    logic [`PROG_ADDR_BITS-1:0] fetch_addr;
    logic [31:0]                instr;
    logic                       cpu_step;
    logic                       cpu_rst;
    logic                       cpu_running;

    logic fetch_check;
    logic run_check;
    logic exp_running;
    int   exp_rst_count;
    int   error_count;
    int   check_count;
    int   cycle_count = 0;

    logic [`PROG_ADDR_BITS-1:0] word_addr [NUM_WORDS];

    always #5 clk_100mhz = ~clk_100mhz;

    program_loader_top dut_i (
        .clk_100mhz  (clk_100mhz),
        .arst_n      (arst_n),
        .uart_rxd    (uart_rxd),
        .step_req    (step_req),
        .fetch_addr  (fetch_addr),
        .instr       (instr),
        .cpu_step    (cpu_step),
        .cpu_rst     (cpu_rst),
        .cpu_running (cpu_running)
    );

    loader_checker chk_i (
        .clk_100mhz    (clk_100mhz),
        .arst_n        (arst_n),
        .step_req      (step_req),
        .fetch_addr    (fetch_addr),
        .instr         (instr),
        .cpu_step      (cpu_step),
        .cpu_rst       (cpu_rst),
        .cpu_running   (cpu_running),
        .fetch_check   (fetch_check),
        .run_check     (run_check),
        .exp_running   (exp_running),
        .exp_rst_count (exp_rst_count),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks, all entered and left 1 ns after a rising edge

    task automatic line_bit(input logic b);
        uart_rxd = b;
        repeat (`CLOCKS_PER_BAUD) @(posedge clk_100mhz);
        #1;
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        line_bit(1'b0);                         // start bit
        for (int i = 0; i < 8; i++) line_bit(b[i]);
        line_bit(stop_bit);
        line_bit(1'b1);                         // idle gap
    endtask

    task automatic write_word(input logic [`PROG_ADDR_BITS-1:0] addr, input logic [31:0] data);
        logic [15:0] addr16;
        addr16 = 16'(addr);
        send_frame(loader_pkg::CMD_WRITE, 1'b1);
        send_frame(addr16[15:8], 1'b1);
        send_frame(addr16[7:0], 1'b1);
        for (int i = 3; i >= 0; i--) send_frame(data[8*i +: 8], 1'b1);
    endtask

    task automatic check_fetch(input logic [`PROG_ADDR_BITS-1:0] addr);
        fetch_addr  = addr;
        fetch_check = 1'b1;
        @(posedge clk_100mhz);
        #1;
        fetch_check = 1'b0;
        @(posedge clk_100mhz);  // checker compares instr here
        #1;
    endtask

    task automatic check_run_state(input logic running, input int rst_pulses);
        exp_running   = running;
        exp_rst_count = rst_pulses;
        run_check     = 1'b1;
        @(posedge clk_100mhz);
        #1;
        run_check = 1'b0;
    endtask

    task automatic pulse_step();
        step_req = 1'b1;
        @(posedge clk_100mhz);
        #1;
        step_req = 1'b0;
        repeat (3) @(posedge clk_100mhz);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        arst_n        = 1'b0;
        uart_rxd      = 1'b1;
        step_req      = 1'b0;
        fetch_addr    = '0;
        fetch_check   = 1'b0;
        run_check     = 1'b0;
        exp_running   = 1'b0;
        exp_rst_count = 0;
        repeat (4) @(posedge clk_100mhz);
        #1;
        arst_n = 1'b1;
        @(posedge clk_100mhz);
        #1;
        check_run_state(1'b0, 0);

        // scattered even addresses, 134 = 2 * 67 keeps them distinct
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_addr[i] = `PROG_ADDR_BITS'(i * 134 + 6);
            write_word(word_addr[i], chk_i.ref_word(word_addr[i]));
        end
        for (int i = 0; i < NUM_WORDS; i++) check_fetch(word_addr[i]);

        send_frame(loader_pkg::CMD_START, 1'b1);
        check_run_state(1'b1, 0);
        send_frame(loader_pkg::CMD_RESET, 1'b1);   // running must not change
        check_run_state(1'b1, 1);
        send_frame(loader_pkg::CMD_HALT, 1'b1);
        check_run_state(1'b0, 1);
        pulse_step();
        pulse_step();

        // unknown opcode, then a start frame with a low stop bit
        send_frame(8'h7a, 1'b1);
        send_frame(loader_pkg::CMD_START, 1'b0);
        check_run_state(1'b0, 1);
        for (int i = 0; i < NUM_WORDS; i++) check_fetch(word_addr[i]);
        write_word(EXTRA_ADDR, chk_i.ref_word(EXTRA_ADDR));
        check_fetch(EXTRA_ADDR);

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run limit, twice the nominal frame time of the whole sequence
    always @(posedge clk_100mhz) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, test sequence did not finish", cycle_count);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* program_loader.f */
+incdir+rtl
rtl/loader_pkg.sv
rtl/loader_if.sv
rtl/uart_rx.sv
rtl/loader_cmd_parser.sv
rtl/program_ram.sv
rtl/run_control.sv
rtl/program_loader_top.sv
verif/loader_checker.sv
verif/tb_program_loader.sv

/* Bender.yml */
package:
  name: program_loader

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/loader_pkg.sv
      - rtl/loader_if.sv
      - rtl/uart_rx.sv
      - rtl/loader_cmd_parser.sv
      - rtl/program_ram.sv
      - rtl/run_control.sv
      - rtl/program_loader_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/loader_checker.sv
      - verif/tb_program_loader.sv
